/* Makefile */
TOOL       = verilator
TOP        = ccu_tb
FILELIST   = project.f
OBJ_DIR    = obj_dir
FLAGS      = --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir $(OBJ_DIR)
LINT_FLAGS = --lint-only --timing -Wall --top-module $(TOP)
PASS_MSG   = Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* biu/biu_seq.sv */
// Bus sequencer that splits one command into word beats and assembles the returning read line
`timescale 1ns/1ns

module biu_seq (
    input  logic                clk,
    input  logic                i_arst_n,

    // Command from the arbiter
    input  logic                i_en,
    input  biu_pkg::biu_cmd_t   i_cmd,
    output logic                o_done,
    output ccu_pkg::line_t      o_rdata,

    // Beats towards the memory
    input  ccu_pkg::word_t      i_mem_rdata,
    output logic                o_beat_valid,
    output biu_pkg::mem_beat_t  o_beat
);

    localparam int WORD_W = ccu_pkg::WORD_W;

    typedef enum logic [1:0] {
        SEQ_IDLE  = 2'b00,
        SEQ_BEAT  = 2'b01,
        SEQ_DRAIN = 2'b10,
        SEQ_DONE  = 2'b11
    } seq_state_e;

    seq_state_e         state_r;
    seq_state_e         state_next;
    biu_pkg::beat_idx_t beat_cnt_r;
    biu_pkg::beat_idx_t beat_cnt_next;
    biu_pkg::beat_idx_t last_beat;
    biu_pkg::beat_idx_t cap_cnt_r;
    logic               cap_valid_r;
    logic               is_read;
    logic               beat_last;
    logic               start;
    ccu_pkg::line_t     line_r;

    assign is_read       = (i_cmd.func == biu_pkg::BIU_FUNC_READ);
    assign last_beat     = (i_cmd.len == ccu_pkg::CCU_LEN_LINE) ? biu_pkg::LAST_BEAT : '0;
    assign beat_last     = (beat_cnt_r == last_beat);
    assign beat_cnt_next = beat_cnt_r + 1'b1;
    assign start         = (state_r == SEQ_IDLE) && i_en;

    // Reads need one extra cycle for the last word to come back from memory
    always_comb begin
        unique case (state_r)
            SEQ_IDLE:  state_next = i_en ? SEQ_BEAT : SEQ_IDLE;
            SEQ_BEAT:  state_next = !beat_last ? SEQ_BEAT : (is_read ? SEQ_DRAIN : SEQ_DONE);
            SEQ_DRAIN: state_next = SEQ_DONE;
            SEQ_DONE:  state_next = SEQ_IDLE;
            default:   state_next = SEQ_IDLE;
        endcase
    end

    // The beat counter always names the beat currently on o_beat
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_r      <= SEQ_IDLE;
            o_beat_valid <= 1'b0;
            beat_cnt_r   <= '0;
            cap_valid_r  <= 1'b0;
            cap_cnt_r    <= '0;
        end else begin
            state_r     <= state_next;
            // Capture side trails the beat side by the memory read latency
            cap_valid_r <= o_beat_valid && !o_beat.we;
            cap_cnt_r   <= beat_cnt_r;
            if (start) begin
                o_beat_valid <= 1'b1;
                beat_cnt_r   <= '0;
            end else if (state_r == SEQ_BEAT) begin
                o_beat_valid <= !beat_last;
                if (!beat_last) begin
                    beat_cnt_r <= beat_cnt_next;
                end
            end
        end
    end

    // Beat payload walks through consecutive word addresses of the command
    always_ff @(posedge clk) begin
        if (state_r == SEQ_IDLE) begin
            o_beat.we    <= !is_read;
            o_beat.addr  <= i_cmd.addr;
            o_beat.wdata <= i_cmd.data[0 +: WORD_W];
        end else if ((state_r == SEQ_BEAT) && !beat_last) begin
            o_beat.addr  <= o_beat.addr + 1'b1;
            o_beat.wdata <= i_cmd.data[beat_cnt_next * WORD_W +: WORD_W];
        end
    end

    // A word read leaves the upper words of the line at zero
    always_ff @(posedge clk) begin
        if (state_r == SEQ_IDLE) begin
            line_r <= '0;
        end else if (cap_valid_r) begin
            line_r[cap_cnt_r * WORD_W +: WORD_W] <= i_mem_rdata;
        end
    end

    assign o_rdata = line_r;
    assign o_done  = (state_r == SEQ_DONE);

    // The arbiter keeps the enable up until it has seen the done pulse
    a_en_held: assert property (@(posedge clk) disable iff (!i_arst_n)
        $fell(i_en) |-> $past(o_done))
        else $error("bus enable dropped before the transfer completed");

endmodule

/* ccu/ccu_arb.sv */
// Fixed-priority arbiter that grants one requestor at a time and forwards its request to the bus unit
`timescale 1ns/1ns

module ccu_arb #(
    parameter int N_REQ = 3
)(
    input  logic                    clk,
    input  logic                    i_arst_n,

    // Requestor handshake
    input  logic [N_REQ-1:0]        i_req_valid,
    input  ccu_pkg::ccu_req_t       i_req [N_REQ],
    output logic [N_REQ-1:0]        o_req_grant,
    output logic [N_REQ-1:0]        o_req_done,
    output ccu_pkg::line_t          o_rsp_data,

    // Bus interface unit side
    input  logic                    i_biu_done,
    input  ccu_pkg::line_t          i_biu_rdata,
    output logic                    o_biu_en,
    output biu_pkg::biu_cmd_t       o_biu_cmd
);

    localparam int IDX_W = (N_REQ > 1) ? $clog2(N_REQ) : 1;

    // Clears the word offset of a line address
    localparam ccu_pkg::addr_t LINE_MASK = ~ccu_pkg::addr_t'(ccu_pkg::WORDS_PER_LINE - 1);

    typedef logic [IDX_W-1:0] req_idx_t;

    typedef enum logic [1:0] {
        ARB_IDLE = 2'b00,
        ARB_BUSY = 2'b01,
        ARB_DONE = 2'b10
    } arb_state_e;

    arb_state_e         state_r;
    arb_state_e         state_next;
    logic [N_REQ-1:0]   pick;
    req_idx_t           pick_idx;
    req_idx_t           idx_r;
    logic               arb_idle;
    logic               any_valid;
    logic [N_REQ-1:0]   grant_next;
    logic [N_REQ-1:0]   done_next;
    logic               biu_en_next;
    ccu_pkg::ccu_req_t  sel_req;

    assign arb_idle  = (state_r == ARB_IDLE);
    assign any_valid = |i_req_valid;

    // Isolate the lowest set valid bit, so requestor 0 always wins
    assign pick = i_req_valid & (~i_req_valid + 1'b1);

    // The pick is one-hot or zero, so OR-ing the indices gives the binary index
    always_comb begin
        pick_idx = '0;
        for (int k = 0; k < N_REQ; k++) begin
            if (pick[k]) begin
                pick_idx = pick_idx | req_idx_t'(k);
            end
        end
    end

    // The winner is only latched while idle and stays fixed until the arbiter returns
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            idx_r <= '0;
        end else if (arb_idle) begin
            idx_r <= pick_idx;
        end
    end

    // Idle picks, busy waits for the bus unit, done lasts exactly one cycle
    always_comb begin
        state_next  = state_r;
        grant_next  = '0;
        done_next   = '0;
        biu_en_next = 1'b0;

        unique case (state_r)
            ARB_IDLE: begin
                grant_next  = pick;
                biu_en_next = any_valid;
                state_next  = any_valid ? ARB_BUSY : ARB_IDLE;
            end
            ARB_BUSY: begin
                done_next[idx_r] = i_biu_done;
                // Enable drops right after the bus unit reports completion
                biu_en_next      = !i_biu_done && i_req_valid[idx_r];
                state_next       = i_biu_done ? ARB_DONE : ARB_BUSY;
            end
            ARB_DONE: begin
                state_next = ARB_IDLE;
            end
            default: begin
                state_next = ARB_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_r     <= ARB_IDLE;
            o_req_grant <= '0;
            o_req_done  <= '0;
            o_biu_en    <= 1'b0;
        end else begin
            state_r     <= state_next;
            o_req_grant <= grant_next;
            o_req_done  <= done_next;
            o_biu_en    <= biu_en_next;
        end
    end

    assign sel_req = i_req[pick_idx];

    // Command is captured from the winner in the same cycle as the pick
    always_ff @(posedge clk) begin
        if (arb_idle) begin
            o_biu_cmd.func <= sel_req.we ? biu_pkg::BIU_FUNC_WRITE : biu_pkg::BIU_FUNC_READ;
            o_biu_cmd.len  <= sel_req.len;
            o_biu_cmd.addr <= (sel_req.len == ccu_pkg::CCU_LEN_LINE) ?
                              (sel_req.addr & LINE_MASK) : sel_req.addr;
            o_biu_cmd.data <= sel_req.data;
        end
    end

    // Response line lines up with the done pulse
    always_ff @(posedge clk) begin
        if ((state_r == ARB_BUSY) && i_biu_done) begin
            o_rsp_data <= i_biu_rdata;
        end
    end

    a_grant_onehot: assert property (@(posedge clk) disable iff (!i_arst_n)
        $onehot0(o_req_grant))
        else $error("more than one grant bit high");

    a_done_onehot: assert property (@(posedge clk) disable iff (!i_arst_n)
        $onehot0(o_req_done))
        else $error("more than one done bit high");

    a_en_in_busy: assert property (@(posedge clk) disable iff (!i_arst_n)
        $rose(o_biu_en) |-> (state_r == ARB_BUSY))
        else $error("bus enable rose outside the busy state");

endmodule

/* common/biu_pkg.sv */
// Bus command and memory beat types used between the arbiter, the bus sequencer and the memory

package biu_pkg;

    // Index of a word beat within one line
    localparam int BEAT_IDX_W = $clog2(ccu_pkg::WORDS_PER_LINE);

    typedef logic [BEAT_IDX_W-1:0] beat_idx_t;

    // Index of the final beat of a line transfer
    localparam beat_idx_t LAST_BEAT = beat_idx_t'(ccu_pkg::WORDS_PER_LINE - 1);

    // Bus function carried with every command
    typedef enum logic {
        BIU_FUNC_READ  = 1'b0,
        BIU_FUNC_WRITE = 1'b1
    } biu_func_e;

    // Command from the arbiter to the sequencer, stable while the enable is high
    typedef struct packed {
        biu_func_e          func;
        ccu_pkg::ccu_len_e  len;
        ccu_pkg::addr_t     addr;
        ccu_pkg::line_t     data;
    } biu_cmd_t;

    // One word beat towards the line memory
    typedef struct packed {
        logic               we;
        ccu_pkg::addr_t     addr;
        ccu_pkg::word_t     wdata;
    } mem_beat_t;

endpackage

/* common/ccu_pkg.sv */
// Requestor-side request and response types, shared by the arbiter, the top level and the testbench

package ccu_pkg;

    // Basic widths of the unit
    localparam int WORD_W         = 32;
    localparam int ADDR_W         = 32;
    localparam int WORDS_PER_LINE = 4;
    localparam int LINE_W         = WORD_W * WORDS_PER_LINE;

    // One data word
    typedef logic [WORD_W-1:0] word_t;

    // A word address, so consecutive words differ by one
    typedef logic [ADDR_W-1:0] addr_t;

    // One cache line, word k sits at bits WORD_W*k and up
    typedef logic [LINE_W-1:0] line_t;

    // Transfer length of a request
    typedef enum logic {
        CCU_LEN_WORD = 1'b0,
        CCU_LEN_LINE = 1'b1
    } ccu_len_e;

    // A request as presented by one requestor
    // A word request carries its write word in word 0 of data
    // A line request gets its low address bits cleared by the arbiter
    typedef struct packed {
        logic     we;
        ccu_len_e len;
        addr_t    addr;
        line_t    data;
    } ccu_req_t;

endpackage

/* project.f */
+incdir+verif
common/ccu_pkg.sv
common/biu_pkg.sv
ccu/ccu_arb.sv
biu/biu_seq.sv
src/line_mem.sv
src/ccu_top.sv
verif/ccu_tb.sv

/* src/ccu_top.sv */
// Top level of the communications unit, arbiter feeding the bus sequencer feeding the line memory
`timescale 1ns/1ns

module ccu_top #(
    parameter int N_REQ     = 3,
    parameter int MEM_WORDS = 256
)(
    input  logic                clk,
    input  logic                i_arst_n,

    // Requestor ports
    input  logic [N_REQ-1:0]    i_req_valid,
    input  ccu_pkg::ccu_req_t   i_req [N_REQ],
    output logic [N_REQ-1:0]    o_req_grant,
    output logic [N_REQ-1:0]    o_req_done,
    output ccu_pkg::line_t      o_rsp_data
);

    // Arbiter to sequencer
    logic               biu_en;
    biu_pkg::biu_cmd_t  biu_cmd;
    logic               biu_done;
    ccu_pkg::line_t     biu_rdata;

    // Sequencer to memory
    logic               beat_valid;
    biu_pkg::mem_beat_t beat;
    ccu_pkg::word_t     mem_rdata;

    ccu_arb #(
        .N_REQ          (N_REQ)
    ) u_arb (
        .clk            (clk),
        .i_arst_n       (i_arst_n),
        .i_req_valid    (i_req_valid),
        .i_req          (i_req),
        .o_req_grant    (o_req_grant),
        .o_req_done     (o_req_done),
        .o_rsp_data     (o_rsp_data),
        .i_biu_done     (biu_done),
        .i_biu_rdata    (biu_rdata),
        .o_biu_en       (biu_en),
        .o_biu_cmd      (biu_cmd)
    );

    biu_seq u_seq (
        .clk            (clk),
        .i_arst_n       (i_arst_n),
        .i_en           (biu_en),
        .i_cmd          (biu_cmd),
        .o_done         (biu_done),
        .o_rdata        (biu_rdata),
        .i_mem_rdata    (mem_rdata),
        .o_beat_valid   (beat_valid),
        .o_beat         (beat)
    );

    line_mem #(
        .MEM_WORDS      (MEM_WORDS)
    ) u_mem (
        .clk            (clk),
        .i_beat_valid   (beat_valid),
        .i_beat         (beat),
        .o_rdata        (mem_rdata)
    );

endmodule

/* src/line_mem.sv */
// Word-wide backing store for the bus sequencer, written and read one beat per cycle
`timescale 1ns/1ns

module line_mem #(
    parameter int MEM_WORDS = 256
)(
    input  logic                clk,
    input  logic                i_beat_valid,
    input  biu_pkg::mem_beat_t  i_beat,
    output ccu_pkg::word_t      o_rdata
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    typedef logic [IDX_W-1:0] mem_idx_t;

    ccu_pkg::word_t mem [MEM_WORDS];
    mem_idx_t       idx;

    // Depth must be a power of two so that the low address bits cover it exactly
    if ((1 << IDX_W) != MEM_WORDS) begin : g_depth_check
        $error("MEM_WORDS must be a power of two");
    end

    // Only the low address bits are decoded, higher bits alias
    assign idx = i_beat.addr[IDX_W-1:0];

    // Read data is registered and appears the cycle after the beat
    always_ff @(posedge clk) begin
        if (i_beat_valid) begin
            if (i_beat.we) begin
                mem[idx] <= i_beat.wdata;
            end else begin
                o_rdata <= mem[idx];
            end
        end
    end

endmodule

/* verif/ccu_tests.svh */
// Directed test tasks for the communications unit, included inside the testbench top module

    // Nothing may be granted or completed while no requestor is valid
    task automatic test_reset_idle();
        repeat (5) begin
            step();
            compare_value("o_req_grant after reset", ccu_pkg::line_t'(req_grant), '0);
            compare_value("o_req_done after reset", ccu_pkg::line_t'(req_done), '0);
        end
    endtask

    task automatic test_line_rw();
        run_and_check(0, 1'b1, LEN_LINE, 32'h0000_0040, rand_line());
        compare_value("o_req_done on line write", ccu_pkg::line_t'(last_done), 'h1);
        run_and_check(0, 1'b0, LEN_LINE, 32'h0000_0040, '0);
        compare_value("o_req_done on line read", ccu_pkg::line_t'(last_done), 'h1);
    endtask

    // The word write uses an aliased address, and the line read an unaligned one
    task automatic test_word_merge();
        run_and_check(1, 1'b1, LEN_LINE, 32'h0000_0080, rand_line());
        run_and_check(1, 1'b1, LEN_WORD, 32'h8000_0082, rand_line());
        run_and_check(2, 1'b0, LEN_LINE, 32'h0000_0081, '0);
        run_and_check(0, 1'b0, LEN_WORD, 32'h0000_0082, '0);
    endtask

    task automatic test_three_way();
        ccu_pkg::line_t d [N_REQ];
        for (int i = 0; i < N_REQ; i++) begin
            d[i] = rand_line();
        end
        for (int pass = 0; pass < 2; pass++) begin
            done_order.delete();
            fork
                run_and_check(0, pass == 0, LEN_LINE, 32'h0000_0100, d[0]);
                run_and_check(1, pass == 0, LEN_LINE, 32'h0000_0104, d[1]);
                run_and_check(2, pass == 0, LEN_LINE, 32'h0000_0108, d[2]);
            join
            for (int i = 0; i < N_REQ; i++) begin
                compare_value($sformatf("done order slot %0d", i),
                              ccu_pkg::line_t'(done_order[i]), ccu_pkg::line_t'(i));
            end
        end
    endtask

    // A read of a word never written is turned into a write of the same request
    task automatic test_random();
        int                 idx;
        logic [31:0]        r;
        logic               we;
        ccu_pkg::ccu_len_e  len;
        ccu_pkg::addr_t     addr;
        repeat (N_RAND) begin
            idx  = int'($unsigned($random(seed)) % N_REQ);
            r    = $random(seed);
            we   = r[0];
            len  = ccu_pkg::ccu_len_e'(r[1]);
            addr = req_base(len, $random(seed));
            for (int k = 0; k < req_words(len); k++) begin
                if (!ref_written[mem_slot(addr + k)]) begin
                    we = 1'b1;
                end
            end
            run_and_check(idx, we, len, addr, rand_line());
        end
    endtask

/* verif/ccu_tb.sv */
// Testbench top for the communications unit; runs the directed tests from the included test file
`timescale 1ns/1ns

module ccu_tb;

    localparam int N_REQ      = 3;
    localparam int MEM_WORDS  = 256;
    localparam int MEM_IDX_W  = $clog2(MEM_WORDS);
    localparam int CLK_PERIOD = 8;
    localparam int N_RAND     = 40;
    localparam ccu_pkg::ccu_len_e LEN_WORD = ccu_pkg::CCU_LEN_WORD;
    localparam ccu_pkg::ccu_len_e LEN_LINE = ccu_pkg::CCU_LEN_LINE;

    // About fifty requests in all, none longer than ten cycles, with a fourfold margin
    localparam int REQ_CYCLES      = 10;
    localparam int WATCHDOG_CYCLES = (N_RAND + 10) * REQ_CYCLES * 4;

    logic               clk;
    logic               arst_n;
    logic [N_REQ-1:0]   req_valid;
    ccu_pkg::ccu_req_t  req [N_REQ];
    logic [N_REQ-1:0]   req_grant;
    logic [N_REQ-1:0]   req_done;
    ccu_pkg::line_t     rsp_data;
    logic [N_REQ-1:0]   valid_at_edge;
    logic [N_REQ-1:0]   last_done;

    // Reference memory, mirrors every write that completed
    ccu_pkg::word_t     ref_mem [MEM_WORDS];
    bit                 ref_written [MEM_WORDS];
    int                 done_order [$];
    int                 err_cnt;
    int                 check_cnt;
    integer             seed;

    ccu_top #(
        .N_REQ          (N_REQ),
        .MEM_WORDS      (MEM_WORDS)
    ) DUT (
        .clk            (clk),
        .i_arst_n       (arst_n),
        .i_req_valid    (req_valid),
        .i_req          (req),
        .o_req_grant    (req_grant),
        .o_req_done     (req_done),
        .o_rsp_data     (rsp_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Valid as the arbiter saw it at the last edge, before the requestors drive again
    always @(posedge clk) begin
        valid_at_edge <= req_valid;
    end

    always @(negedge clk) begin
        if (arst_n) begin
            compare_value("o_req_grant | o_req_done on idle requestor",
                          ccu_pkg::line_t'((req_grant | req_done) & ~valid_at_edge), '0);
        end
    end

    task automatic compare_value(input string name, input ccu_pkg::line_t got,
                                 input ccu_pkg::line_t exp);
        check_cnt++;
        assert (got === exp) else begin
            $display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    // Inputs change 1 ns after the rising edge and outputs are read there too
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    function automatic int req_words(input ccu_pkg::ccu_len_e len);
        return (len == LEN_LINE) ? ccu_pkg::WORDS_PER_LINE : 1;
    endfunction

    // A line request works on the line with the two low address bits cleared
    function automatic ccu_pkg::addr_t req_base(input ccu_pkg::ccu_len_e len,
                                                input ccu_pkg::addr_t addr);
        return (len == LEN_LINE) ? {addr[31:2], 2'b00} : addr;
    endfunction

    // The memory decodes only the low address bits
    function automatic int mem_slot(input ccu_pkg::addr_t addr);
        return int'(addr[MEM_IDX_W-1:0]);
    endfunction

    function automatic ccu_pkg::line_t rand_line();
        ccu_pkg::line_t l;
        for (int k = 0; k < ccu_pkg::WORDS_PER_LINE; k++) begin
            l[32*k +: 32] = $random(seed);
        end
        return l;
    endfunction

    // Issues one request, counts grant pulses until done, then checks read data
    task automatic run_and_check(input int idx, input logic we, input ccu_pkg::ccu_len_e len,
                                 input ccu_pkg::addr_t addr, input ccu_pkg::line_t data);
        ccu_pkg::addr_t base;
        ccu_pkg::line_t exp_line;
        int             grants;
        base           = req_base(len, addr);
        exp_line       = '0;
        grants         = 0;
        req[idx]       = '{we: we, len: len, addr: addr, data: data};
        req_valid[idx] = 1'b1;
        do begin
            step();
            if (req_grant[idx]) begin
                grants++;
            end
        end while (!req_done[idx]);
        last_done      = req_done;
        req_valid[idx] = 1'b0;
        done_order.push_back(idx);
        compare_value($sformatf("grant pulses of requestor %0d", idx),
                      ccu_pkg::line_t'(grants), ccu_pkg::line_t'(1));
        for (int k = 0; k < req_words(len); k++) begin
            if (we) begin
                ref_mem[mem_slot(base + k)]     = data[32*k +: 32];
                ref_written[mem_slot(base + k)] = 1'b1;
            end else begin
                exp_line[32*k +: 32] = ref_mem[mem_slot(base + k)];
            end
        end
        if (!we && len == LEN_LINE) begin
            compare_value($sformatf("o_rsp_data line to requestor %0d", idx), rsp_data, exp_line);
        end else if (!we) begin
            compare_value($sformatf("o_rsp_data word to requestor %0d", idx),
                          ccu_pkg::line_t'(rsp_data[31:0]), exp_line);
        end
    endtask

    `include "ccu_tests.svh"

    initial begin
        seed      = 32'h90fe_9737;
        err_cnt   = 0;
        check_cnt = 0;
        clk       = 1'b0;
        arst_n    = 1'b0;
        req_valid = '0;
        last_done = '0;
        for (int i = 0; i < N_REQ; i++) begin
            req[i] = '0;
        end
        repeat (3) @(posedge clk);
        #1;
        arst_n = 1'b1;
        test_reset_idle();
        test_line_rw();
        test_word_merge();
        test_three_way();
        test_random();
        $display("Checks: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, a request never completed",
                 WATCHDOG_CYCLES);
        $display("Verification failed");
        $finish;
    end

endmodule
